//--- tb/bridge_trace.txt
// op_address_writedata_byteenable_readdata_response, one command per line
// op 1 read 2 write, response 0 okay 3 decode error, readdata 0 for writes
2_000_11223344_f_00000000_0
1_000_00000000_0_11223344_0
1_003_00000000_0_c0de0303_0
2_001_aabbccdd_3_00000000_0
1_001_00000000_0_c0deccdd_0
2_001_55667788_c_00000000_0
1_001_00000000_0_5566ccdd_0
2_040_deadbeef_f_00000000_3
1_040_00000000_0_00000000_3
2_03f_01020304_5_00000000_0
1_03f_00000000_0_c0023f04_0
2_002_89abcdef_f_00000000_0
2_003_00000000_8_00000000_0
1_002_00000000_0_89abcdef_0
1_003_00000000_0_00de0303_0
1_3ff_00000000_0_00000000_3
2_010_fedcba98_9_00000000_0
1_010_00000000_0_fede1098_0
2_000_00000000_0_00000000_0
1_000_00000000_0_11223344_0
2_020_13579bdf_f_00000000_0
1_021_00000000_0_c0de2121_0
1_020_00000000_0_13579bdf_0
2_020_2468ace0_6_00000000_0
1_020_00000000_0_1368acdf_0
1_080_00000000_0_00000000_3
2_005_0f0f0f0f_f_00000000_0
1_005_00000000_0_0f0f0f0f_0
1_03e_00000000_0_c0de3e3e_0
1_001_00000000_0_5566ccdd_0

//--- filelist.f
verilog/avmm_cmd_pkg.sv
verilog/avmm_rsp_pkg.sv
verilog/wait_skid_stage.sv
verilog/master_port_stage.sv
verilog/avmm_pipeline_bridge.sv
tb/avmm_bridge_checker.sv
tb/tb_avmm_bridge.sv

//--- Makefile
# verilator build and run of the avalon-mm pipeline bridge testbench

SIM  := obj_dir/Vtb_avmm_bridge
SRCS := $(shell cat filelist.f)

.PHONY: run clean

run: $(SIM) tb/bridge_trace.txt
	./$(SIM) +verilator+error+limit+1000 > sim.log 2>&1; cat sim.log
	@! grep -q "ERRORS FOUND" sim.log
	@grep -q "NO ERRORS" sim.log

$(SIM): filelist.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module tb_avmm_bridge -f filelist.f

clean:
	rm -rf obj_dir sim.log

//--- tb/tb_avmm_bridge.sv
`timescale 1ns/100ps
`default_nettype none

module tb_avmm_bridge;

    // ------------------------------------------------------------
    // constants
    // ------------------------------------------------------------
    localparam int reset_cycles = 16;
    localparam int max_cmds     = 64;
    // slave memory depth
    // addresses from here up decode to an error
    localparam int mem_depth    = 64;
    // cycle budget per trace line for the watchdog
    localparam int cycles_per_cmd = 40;

    // ------------------------------------------------------------
    // DUT signals
    // ------------------------------------------------------------
    logic               clk = 1'b0;
    logic               reset;
    avmm_cmd_pkg::cmd_t s0_cmd;
    logic               s0_waitrequest;
    avmm_rsp_pkg::rsp_t s0_rsp;
    avmm_cmd_pkg::cmd_t m0_cmd;
    logic               m0_waitrequest;
    avmm_rsp_pkg::rsp_t m0_rsp;

    // ------------------------------------------------------------
    // testbench state
    // ------------------------------------------------------------
    // one trace word per command
    // op, address, writedata, byteenable, expected readdata, response
    logic [87:0]        trace_mem [0:max_cmds-1];
    int                 num_cmds = 0;
    logic               trace_ready = 1'b0;
    // error counters
    int                 value_errors = 0;
    int                 other_errors = 0;
    int                 assert_fails;
    // slave model
    logic [31:0]        slave_mem [0:mem_depth-1];
    logic [15:0]        lfsr_state = 16'd79;
    logic               xfer_pending = 1'b0;
    avmm_cmd_pkg::cmd_t xfer_cmd;
    int                 xfer_count = 0;
    // response monitor
    int                 rsp_count = 0;
    // driver
    logic               stalled;

    avmm_pipeline_bridge i_dut (
        .clk            (clk),
        .reset          (reset),
        .s0_cmd         (s0_cmd),
        .s0_waitrequest (s0_waitrequest),
        .s0_rsp         (s0_rsp),
        .m0_cmd         (m0_cmd),
        .m0_waitrequest (m0_waitrequest),
        .m0_rsp         (m0_rsp)
    );

    // 100 ns period
    always #50 clk = ~clk;

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------
    // 16-bit fibonacci lfsr with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    // command fields of trace line idx
    function automatic avmm_cmd_pkg::cmd_t trace_cmd(input int idx);
        avmm_cmd_pkg::cmd_t cmd;
        cmd.op         = avmm_cmd_pkg::opcode_t'(trace_mem[idx][85:84]);
        cmd.address    = trace_mem[idx][81:72];
        cmd.writedata  = trace_mem[idx][71:40];
        cmd.byteenable = trace_mem[idx][39:36];
        return cmd;
    endfunction

    // printable form of a command
    function automatic string cmd_text(input avmm_cmd_pkg::cmd_t cmd);
        return $sformatf("%s addr %h data %h be %h", cmd.op.name(), cmd.address,
                         cmd.writedata, cmd.byteenable);
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        other_errors++;
    endtask

    // one compare task per kind of result
    task automatic check_cmd(input string name, input avmm_cmd_pkg::cmd_t exp,
                             input avmm_cmd_pkg::cmd_t act);
        if (act !== exp) begin
            $display("error %s: expected %s, actual %s", name,
                     cmd_text(exp), cmd_text(act));
            value_errors++;
        end
    endtask

    task automatic check_data(input string name,
                              input logic [avmm_cmd_pkg::data_width-1:0] exp,
                              input logic [avmm_cmd_pkg::data_width-1:0] act);
        if (act !== exp) begin
            $display("error %s: expected data %h, actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_resp(input string name, input avmm_rsp_pkg::resp_code_t exp,
                              input avmm_rsp_pkg::resp_code_t act);
        if (act !== exp) begin
            $display("error %s: expected %s, actual %s", name, exp.name(), act.name());
            value_errors++;
        end
    endtask

    task automatic check_reset_state;
        if (s0_waitrequest !== 1'b1)
            report_failure("s0_waitrequest is not high during reset");
        if (m0_cmd.op !== avmm_cmd_pkg::op_idle)
            report_failure("m0 command is not idle during reset");
        if (s0_rsp.readdatavalid !== 1'b0 || s0_rsp.writeresponsevalid !== 1'b0)
            report_failure("an s0 response valid is high during reset");
    endtask

    // ------------------------------------------------------------
    // slave side
    // ------------------------------------------------------------
    // answers a transfer seen at the last edge and does the memory access
    task automatic serve_command(input avmm_cmd_pkg::cmd_t cmd);
        logic decode_err;
        if (xfer_count >= num_cmds) begin
            report_failure("m0 carried more commands than the trace holds");
        end else begin
            check_cmd($sformatf("m0 command %0d", xfer_count), trace_cmd(xfer_count), cmd);
        end
        xfer_count++;
        decode_err = int'(cmd.address) >= mem_depth;
        m0_rsp.response = decode_err ? avmm_rsp_pkg::resp_decode_error
                                     : avmm_rsp_pkg::resp_okay;
        if (cmd.op == avmm_cmd_pkg::op_read) begin
            m0_rsp.readdatavalid = 1'b1;
            m0_rsp.readdata      = decode_err ? 32'h0 : slave_mem[cmd.address[5:0]];
        end else begin
            m0_rsp.writeresponsevalid = 1'b1;
            // byte-lane write with nothing stored past the decode boundary
            for (int b = 0; b < avmm_cmd_pkg::byteen_width; b++) begin
                if (!decode_err && cmd.byteenable[b])
                    slave_mem[cmd.address[5:0]][b*8 +: 8] = cmd.writedata[b*8 +: 8];
            end
        end
    endtask

    initial begin : slave_model
        m0_waitrequest = 1'b0;
        m0_rsp         = '0;
        // fill pattern tied to the full word address
        for (int i = 0; i < mem_depth; i++)
            slave_mem[i] = 32'hc0de0000 | 32'(i * 257);
        forever begin
            @(posedge clk);
            #10;
            m0_rsp = '0;
            // response one cycle after the transfer
            if (xfer_pending)
                serve_command(xfer_cmd);
            lfsr_state     = lfsr_step(lfsr_state);
            m0_waitrequest = lfsr_state[0];
            // transfer happens at the coming edge
            xfer_pending = !reset && m0_cmd.op != avmm_cmd_pkg::op_idle && !m0_waitrequest;
            xfer_cmd     = m0_cmd;
        end
    end

    // ------------------------------------------------------------
    // s0 response monitor
    // ------------------------------------------------------------
    task automatic take_response(input avmm_rsp_pkg::rsp_t rsp);
        string name;
        avmm_cmd_pkg::opcode_t exp_op;
        if (rsp.readdatavalid && rsp.writeresponsevalid) begin
            report_failure("read and write response valid in the same cycle on s0");
        end else if (rsp.readdatavalid || rsp.writeresponsevalid) begin
            name = $sformatf("s0 response %0d", rsp_count);
            if (rsp_count >= num_cmds) begin
                report_failure("s0 response arrived with no command left to answer");
            end else begin
                exp_op = trace_cmd(rsp_count).op;
                if (rsp.readdatavalid && exp_op != avmm_cmd_pkg::op_read) begin
                    report_failure($sformatf("%s is read data for a write", name));
                end else if (rsp.writeresponsevalid && exp_op != avmm_cmd_pkg::op_write) begin
                    report_failure($sformatf("%s is a write response for a read", name));
                end else begin
                    if (rsp.readdatavalid)
                        check_data(name, trace_mem[rsp_count][35:4], rsp.readdata);
                    check_resp(name, avmm_rsp_pkg::resp_code_t'(trace_mem[rsp_count][1:0]),
                               rsp.response);
                end
            end
            rsp_count++;
        end
    endtask

    initial begin : response_monitor
        forever begin
            @(posedge clk);
            #10;
            if (!reset)
                take_response(s0_rsp);
        end
    end

    // ------------------------------------------------------------
    // watchdog
    // ------------------------------------------------------------
    initial begin : watchdog
        wait (trace_ready);
        repeat (num_cmds * cycles_per_cmd + reset_cycles) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles",
                 num_cmds * cycles_per_cmd + reset_cycles);
        $display("ERRORS FOUND");
        $finish;
    end

    // ------------------------------------------------------------
    // main sequence with reset, master driver and summary
    // ------------------------------------------------------------
    initial begin : main_sequence
        reset  = 1'b1;
        s0_cmd = '0;
        $readmemh("tb/bridge_trace.txt", trace_mem);
        // trace ends at the first line that is neither read nor write
        while (num_cmds < max_cmds &&
               (trace_mem[num_cmds][87:84] == 4'h1 || trace_mem[num_cmds][87:84] == 4'h2))
            num_cmds++;
        if (num_cmds == 0)
            report_failure("the trace file holds no commands");
        trace_ready = 1'b1;

        repeat (reset_cycles) begin
            @(posedge clk);
            #10;
            check_reset_state();
        end
        reset = 1'b0;
        // m0 is idle, so waitrequest drops at the first edge
        @(posedge clk);
        #10;
        if (s0_waitrequest !== 1'b0)
            report_failure("s0_waitrequest did not fall at the first edge after reset");

        for (int i = 0; i < num_cmds; i++) begin
            s0_cmd = trace_cmd(i);
            // waitrequest is registered, so its value now holds at the next edge
            do begin
                stalled = s0_waitrequest;
                @(posedge clk);
                #10;
            end while (stalled);
            s0_cmd.op = avmm_cmd_pkg::op_idle;
            repeat (i % 3) begin
                @(posedge clk);
                #10;
            end
        end

        wait (rsp_count >= num_cmds);
        // quiet period to catch late duplicates
        repeat (10) @(posedge clk);
        #10;
        if (xfer_count != num_cmds)
            report_failure($sformatf("m0 carried %0d commands for %0d trace lines",
                                     xfer_count, num_cmds));
        if (rsp_count != num_cmds)
            report_failure($sformatf("s0 returned %0d responses for %0d trace lines",
                                     rsp_count, num_cmds));
        assert_fails = i_dut.i_master_port.i_checker.fail_count;
        $display("summary: %0d value errors, %0d other errors, %0d assertion failures",
                 value_errors, other_errors, assert_fails);
        if (value_errors + other_errors + assert_fails == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/avmm_bridge_checker.sv
`timescale 1ns/100ps
`default_nettype none

// protocol checks on m0 and on the response register
module avmm_bridge_checker (
    input  wire                  clk,
    input  wire                  reset,
    input  avmm_cmd_pkg::cmd_t   m0_cmd,
    input  logic                 m0_waitrequest,
    input  avmm_rsp_pkg::rsp_t   m0_rsp,
    input  avmm_rsp_pkg::rsp_t   s0_rsp
);

    // failed assertions so far, read by the testbench
    int unsigned fail_count = 0;

    // ------------------------------------------------------------
    // properties
    // ------------------------------------------------------------
    // a stalled command must not change
    property cmd_held_under_wait;
        @(posedge clk) disable iff (reset)
        (m0_cmd.op != avmm_cmd_pkg::op_idle && m0_waitrequest) |=> $stable(m0_cmd);
    endproperty

    // response register is a plain one-cycle delay
    property rsp_one_cycle_delay;
        @(posedge clk) disable iff (reset)
        1'b1 |=> (s0_rsp == $past(m0_rsp));
    endproperty

    // at most one valid per cycle
    property rsp_valids_exclusive;
        @(posedge clk) disable iff (reset)
        !(s0_rsp.readdatavalid && s0_rsp.writeresponsevalid);
    endproperty

    a_cmd_held: assert property (cmd_held_under_wait)
        else begin
            $error("m0 command changed while waitrequest was high");
            fail_count++;
        end

    a_rsp_delay: assert property (rsp_one_cycle_delay)
        else begin
            $error("s0 response differs from the m0 response one cycle earlier");
            fail_count++;
        end

    a_rsp_excl: assert property (rsp_valids_exclusive)
        else begin
            $error("readdatavalid and writeresponsevalid high together on s0");
            fail_count++;
        end

endmodule

bind master_port_stage avmm_bridge_checker i_checker (
    .clk            (clk),
    .reset          (reset),
    .m0_cmd         (m0_cmd),
    .m0_waitrequest (m0_waitrequest),
    .m0_rsp         (m0_rsp),
    .s0_rsp         (s0_rsp)
);

`default_nettype wire

//--- verilog/avmm_pipeline_bridge.sv
`timescale 1ns/100ps
`default_nettype none

// two-stage avalon-mm pipeline bridge, s0 slave to m0 master
module avmm_pipeline_bridge (
    input  wire                  clk,
    input  wire                  reset,
    input  avmm_cmd_pkg::cmd_t   s0_cmd,
    output logic                 s0_waitrequest,
    output avmm_rsp_pkg::rsp_t   s0_rsp,
    output avmm_cmd_pkg::cmd_t   m0_cmd,
    input  logic                 m0_waitrequest,
    input  avmm_rsp_pkg::rsp_t   m0_rsp
);

    // ------------------------------------------------------------
    // inter-stage signals
    // ------------------------------------------------------------
    // command from skid stage to master port stage
    avmm_cmd_pkg::cmd_t fwd_cmd;
    // internal stall, low whenever the m0 slot is idle
    logic               cmd_stall;

    // waitrequest register and skid buffer
    wait_skid_stage i_wait_skid (
        .clk            (clk),
        .reset          (reset),
        .s0_cmd         (s0_cmd),
        .cmd_stall      (cmd_stall),
        .s0_waitrequest (s0_waitrequest),
        .fwd_cmd        (fwd_cmd)
    );

    // m0 command register and response register
    master_port_stage i_master_port (
        .clk            (clk),
        .reset          (reset),
        .fwd_cmd        (fwd_cmd),
        .m0_waitrequest (m0_waitrequest),
        .cmd_stall      (cmd_stall),
        .m0_cmd         (m0_cmd),
        .m0_rsp         (m0_rsp),
        .s0_rsp         (s0_rsp)
    );

endmodule

`default_nettype wire

//--- verilog/master_port_stage.sv
`timescale 1ns/100ps
`default_nettype none

// registered command toward m0 and registered response path
// back toward s0
module master_port_stage (
    input  wire                  clk,
    input  wire                  reset,
    input  avmm_cmd_pkg::cmd_t   fwd_cmd,
    input  logic                 m0_waitrequest,
    output logic                 cmd_stall,
    output avmm_cmd_pkg::cmd_t   m0_cmd,
    input  avmm_rsp_pkg::rsp_t   m0_rsp,
    output avmm_rsp_pkg::rsp_t   s0_rsp
);

    // ------------------------------------------------------------
    // command side
    // ------------------------------------------------------------
    // stage holds a real transfer, not an idle slot
    logic busy;

    assign busy = (m0_cmd.op != avmm_cmd_pkg::op_idle);

    // an idle stage never stalls, which lets the skid stage
    // assume a low stall by default
    // also low through reset because op is cleared then
    assign cmd_stall = m0_waitrequest & busy;

    // load a new command whenever the current one has gone out
    // or the slot is empty
    // payload fields keep their value through reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            m0_cmd.op <= avmm_cmd_pkg::op_idle;
        end else if (!cmd_stall) begin
            m0_cmd <= fwd_cmd;
        end
    end

    // ------------------------------------------------------------
    // response side
    // ------------------------------------------------------------
    // plain one-cycle delay, no flow control on responses
    // valids and code cleared in reset, read data is don't-care
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            s0_rsp.readdatavalid      <= 1'b0;
            s0_rsp.writeresponsevalid <= 1'b0;
            s0_rsp.response           <= avmm_rsp_pkg::resp_okay;
        end else begin
            s0_rsp <= m0_rsp;
        end
    end

    // note that a write response passes through unconditionally,
    // the slave side decides whether it produces one

endmodule

`default_nettype wire

//--- verilog/wait_skid_stage.sv
`timescale 1ns/100ps
`default_nettype none

// registers s0 waitrequest and keeps a one-entry skid buffer
// so that the command sampled while the stall was still
// invisible to the master is not lost
module wait_skid_stage (
    input  wire                  clk,
    input  wire                  reset,
    input  avmm_cmd_pkg::cmd_t   s0_cmd,
    input  logic                 cmd_stall,
    output logic                 s0_waitrequest,
    output avmm_cmd_pkg::cmd_t   fwd_cmd
);

    // ------------------------------------------------------------
    // state
    // ------------------------------------------------------------
    // captured command while the downstream stage stalls
    avmm_cmd_pkg::cmd_t buf_cmd;
    // forward the buffer instead of the live s0 command
    logic               use_buf;
    // stall seen this cycle but not yet shown to the master
    logic               wait_rise;

    // master sees the stall one cycle late
    assign wait_rise = ~s0_waitrequest & cmd_stall;

    // ------------------------------------------------------------
    // registered waitrequest
    // ------------------------------------------------------------
    // high out of reset, drops on the first edge after it since
    // the next stage holds op_idle and so does not stall
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            s0_waitrequest <= 1'b1;
        end else begin
            s0_waitrequest <= cmd_stall;
        end
    end

    // ------------------------------------------------------------
    // skid buffer
    // ------------------------------------------------------------
    // capture on every stall rise, idle commands included
    // only the op needs a defined value after reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            buf_cmd.op <= avmm_cmd_pkg::op_idle;
        end else if (wait_rise) begin
            buf_cmd <= s0_cmd;
        end
    end

    // buffer select
    // set at reset so the first cycle forwards the idle buffer,
    // otherwise the command present then could be taken twice
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            use_buf <= 1'b1;
        end else if (!cmd_stall) begin
            use_buf <= 1'b0;
        end else if (wait_rise) begin
            use_buf <= 1'b1;
        end
    end

    // pass-through unless the buffer holds the pending command
    assign fwd_cmd = use_buf ? buf_cmd : s0_cmd;

endmodule

`default_nettype wire

//--- verilog/avmm_rsp_pkg.sv
`default_nettype none

// response-side types, flowing from m0 back to s0
package avmm_rsp_pkg;

    // standard avalon response codes
    typedef enum logic [1:0] {
        resp_okay         = 2'b00,
        resp_reserved     = 2'b01,
        resp_slave_error  = 2'b10,
        resp_decode_error = 2'b11
    } resp_code_t;

    // response bundle, 36 bits
    // read data width follows the command side
    typedef struct packed {
        logic                                  readdatavalid;
        logic                                  writeresponsevalid;
        logic [avmm_cmd_pkg::data_width-1:0]   readdata;
        resp_code_t                            response;
    } rsp_t;

endpackage

`default_nettype wire

//--- verilog/avmm_cmd_pkg.sv
`default_nettype none

// command-side types shared by the bridge stages
package avmm_cmd_pkg;

    // ------------------------------------------------------------
    // bus widths
    // ------------------------------------------------------------
    parameter int data_width = 32;
    parameter int addr_width = 10;
    // one byte enable per 8-bit lane
    parameter int byteen_width = data_width / 8;

    // ------------------------------------------------------------
    // command encoding
    // ------------------------------------------------------------
    // read and write are mutually exclusive on the bus, so one opcode
    typedef enum logic [1:0] {
        op_idle  = 2'b00,
        op_read  = 2'b01,
        op_write = 2'b10
    } opcode_t;

    // full command as seen on s0 and m0, 48 bits
    typedef struct packed {
        opcode_t                 op;
        logic [addr_width-1:0]   address;
        logic [data_width-1:0]   writedata;
        logic [byteen_width-1:0] byteenable;
    } cmd_t;

endpackage

`default_nettype wire
